// ==== rtl/cache_pkg.sv ====
package cache_pkg;

    // Bus geometry, one full line per access
    localparam int ADDR_W   = 16;
    localparam int LINE_W   = 128;
    localparam int SEL_W    = 16;
    localparam int OFFSET_W = 4;

    // Source of a data-array write
    typedef enum logic {
        CPU_MERGE = 1'b0,
        MEM_FILL  = 1'b1
    } line_src_e;

    // Source of the memory-port address and data
    typedef enum logic {
        FROM_CACHE  = 1'b0,
        FROM_VICTIM = 1'b1
    } mem_src_e;

endpackage

// ==== rtl/cache_ctrl_if.sv ====
`timescale 1ns/10ps

interface cache_ctrl_if
    import cache_pkg::*;
#(
    parameter int ASSOCIATIVITY = 2
);
    localparam int WAY_W = $clog2(ASSOCIATIVITY);

    // Controller to datapath
    logic [WAY_W-1:0]         way_sel;
    line_src_e                line_src;
    logic                     load;
    logic                     load_lru;

    // Datapath to controller
    logic [ASSOCIATIVITY-1:0] hit;
    logic                     dirty;
    logic [WAY_W-1:0]         lru;

    modport controller (
        output way_sel, line_src, load, load_lru,
        input  hit, dirty, lru
    );

    modport datapath (
        input  way_sel, line_src, load, load_lru,
        output hit, dirty, lru
    );

endinterface

// ==== rtl/cache_datapath.sv ====
`timescale 1ns/10ps

module cache_datapath
    import cache_pkg::*;
#(
    parameter int NUM_LINES     = 8,
    parameter int ASSOCIATIVITY = 2
) (
    input  logic              clk,
    input  logic              rst,
    cache_ctrl_if.datapath    ctrl,
    input  logic [ADDR_W-1:0] cpu_adr,
    input  logic [SEL_W-1:0]  cpu_sel,
    input  logic [LINE_W-1:0] cpu_dat_m,
    input  logic [LINE_W-1:0] mem_dat_s,
    output logic [LINE_W-1:0] cpu_dat_s,
    output logic [ADDR_W-1:0] fill_addr,
    output logic [ADDR_W-1:0] victim_addr,
    output logic [LINE_W-1:0] victim_data
);
    localparam int SETS     = NUM_LINES / ASSOCIATIVITY;
    localparam int WAY_W    = $clog2(ASSOCIATIVITY);
    localparam int IDX_BITS = $clog2(SETS);
    localparam int INDEX_W  = (IDX_BITS > 0) ? IDX_BITS : 1;
    localparam int LNUM_W   = ADDR_W - OFFSET_W;
    localparam int TAG_W    = LNUM_W - IDX_BITS;

    // Storage, one entry per set and way
    logic [TAG_W-1:0]         tag_arr   [SETS][ASSOCIATIVITY];
    logic [LINE_W-1:0]        data_arr  [SETS][ASSOCIATIVITY];
    logic [WAY_W-1:0]         age_arr   [SETS][ASSOCIATIVITY];
    logic [ASSOCIATIVITY-1:0] valid_arr [SETS];
    logic [ASSOCIATIVITY-1:0] dirty_arr [SETS];

    logic [LNUM_W-1:0]        line_num;
    logic [LNUM_W-1:0]        victim_line_num;
    logic [INDEX_W-1:0]       index;
    logic [TAG_W-1:0]         tag;
    logic [LINE_W-1:0]        sel_line;
    logic [LINE_W-1:0]        merged_line;
    logic [WAY_W-1:0]         oldest_way;
    logic [WAY_W-1:0]         victim_way;

    // Address split, SETS is a power of two so the modulo is a bit select
    assign line_num = cpu_adr[ADDR_W-1:OFFSET_W];
    assign index    = INDEX_W'(line_num % SETS);
    assign tag      = TAG_W'(line_num >> IDX_BITS);

    assign fill_addr = {line_num, {OFFSET_W{1'b0}}};

    // Tag compare across all ways of the set
    always_comb begin
        for (int w = 0; w < ASSOCIATIVITY; w++) begin
            ctrl.hit[w] = valid_arr[index][w] && (tag_arr[index][w] == tag);
        end
    end

    // Victim is the first invalid way, else the oldest one
    always_comb begin
        oldest_way = '0;
        for (int w = 1; w < ASSOCIATIVITY; w++) begin
            if (age_arr[index][w] > age_arr[index][oldest_way]) begin
                oldest_way = WAY_W'(w);
            end
        end
        victim_way = oldest_way;
        for (int w = ASSOCIATIVITY - 1; w >= 0; w--) begin
            if (!valid_arr[index][w]) begin
                victim_way = WAY_W'(w);
            end
        end
    end

    assign ctrl.lru   = victim_way;
    assign ctrl.dirty = valid_arr[index][victim_way] && dirty_arr[index][victim_way];

    // Victim line rebuilt from its stored tag and the current index
    assign victim_line_num = (LNUM_W'(tag_arr[index][victim_way]) << IDX_BITS)
                           | LNUM_W'(index);
    assign victim_addr     = {victim_line_num, {OFFSET_W{1'b0}}};
    assign victim_data     = data_arr[index][victim_way];

    // Line of the selected way, also the CPU read data
    assign sel_line  = data_arr[index][ctrl.way_sel];
    assign cpu_dat_s = sel_line;

    // Byte merge of CPU write data into the stored line
    always_comb begin
        for (int b = 0; b < SEL_W; b++) begin
            merged_line[8*b +: 8] = cpu_sel[b] ? cpu_dat_m[8*b +: 8] : sel_line[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load) begin
            tag_arr[index][ctrl.way_sel] <= tag;
            if (ctrl.line_src == MEM_FILL) begin
                data_arr[index][ctrl.way_sel] <= mem_dat_s;
            end else begin
                data_arr[index][ctrl.way_sel] <= merged_line;
            end
        end
    end

    // Valid, dirty and age state
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid_arr[s] <= '0;
                dirty_arr[s] <= '0;
                for (int w = 0; w < ASSOCIATIVITY; w++) begin
                    age_arr[s][w] <= WAY_W'(w);
                end
            end
        end else begin
            if (ctrl.load) begin
                valid_arr[index][ctrl.way_sel] <= 1'b1;
                // A fresh fill is clean, a CPU merge makes it dirty
                dirty_arr[index][ctrl.way_sel] <= (ctrl.line_src == CPU_MERGE);
            end
            if (ctrl.load_lru) begin
                for (int w = 0; w < ASSOCIATIVITY; w++) begin
                    if (WAY_W'(w) == ctrl.way_sel) begin
                        age_arr[index][w] <= '0;
                    end else if (age_arr[index][w] < age_arr[index][ctrl.way_sel]) begin
                        age_arr[index][w] <= age_arr[index][w] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== rtl/eviction_buffer.sv ====
`timescale 1ns/10ps

module eviction_buffer
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              victim_load,
    input  mem_src_e          mem_src,
    input  logic [ADDR_W-1:0] fill_addr,
    input  logic [ADDR_W-1:0] victim_addr,
    input  logic [LINE_W-1:0] victim_data,
    output logic [ADDR_W-1:0] mem_adr,
    output logic [LINE_W-1:0] mem_dat_m
);
    logic [ADDR_W-1:0] held_addr;
    logic [LINE_W-1:0] held_data;

    // Victim address, captured with the line on a dirty miss
    always_ff @(posedge clk) begin
        if (rst) begin
            held_addr <= '0;
        end else if (victim_load) begin
            held_addr <= victim_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (victim_load) begin
            held_data <= victim_data;
        end
    end

    // Fill reads use the request line, write-backs the held victim
    always_comb begin
        if (mem_src == FROM_VICTIM) begin
            mem_adr = held_addr;
        end else begin
            mem_adr = fill_addr;
        end
    end

    // Only meaningful while mem_we is high
    assign mem_dat_m = held_data;

endmodule

// ==== rtl/eviction_buffered_cache_controller.sv ====
`timescale 1ns/10ps

module eviction_buffered_cache_controller
    import cache_pkg::*;
#(
    parameter int ASSOCIATIVITY = 2
) (
    input  logic             clk,
    input  logic             rst,
    cache_ctrl_if.controller ctrl,
    input  logic             cpu_cyc,
    input  logic             cpu_stb,
    input  logic             cpu_we,
    input  logic             mem_ack,
    output logic             cpu_ack,
    output logic             mem_cyc,
    output logic             mem_stb,
    output logic             mem_we,
    output logic [SEL_W-1:0] mem_sel,
    output logic             victim_load,
    output mem_src_e         mem_src
);
    localparam int WAY_W = $clog2(ASSOCIATIVITY);

    typedef enum logic [1:0] {
        IDLE,
        FILL,
        RESPOND,
        WRITEBACK
    } state_e;

    state_e           state;
    logic [WAY_W-1:0] way_q;
    logic [WAY_W-1:0] hit_way;
    logic             wb_pending;
    logic             cpu_req;
    logic             any_hit;

    assign cpu_req = cpu_cyc && cpu_stb;
    assign any_hit = |ctrl.hit;

    // One-hot hit vector to way index
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < ASSOCIATIVITY; w++) begin
            if (ctrl.hit[w]) begin
                hit_way = WAY_W'(w);
            end
        end
    end

    // Datapath strobes decoded from the current state
    always_comb begin
        ctrl.way_sel  = way_q;
        ctrl.line_src = CPU_MERGE;
        ctrl.load     = 1'b0;
        ctrl.load_lru = 1'b0;
        victim_load   = 1'b0;
        case (state)
            IDLE: begin
                // Grab the dirty victim before the fill overwrites it
                victim_load = cpu_req && !any_hit && ctrl.dirty;
            end
            FILL: begin
                ctrl.line_src = MEM_FILL;
                ctrl.load     = mem_ack;
            end
            RESPOND: begin
                // Write data merges while the CPU still holds its request
                ctrl.load     = cpu_we;
                ctrl.load_lru = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign mem_src = (state == WRITEBACK) ? FROM_VICTIM : FROM_CACHE;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            way_q      <= '0;
            wb_pending <= 1'b0;
            cpu_ack    <= 1'b0;
            mem_cyc    <= 1'b0;
            mem_stb    <= 1'b0;
            mem_we     <= 1'b0;
            mem_sel    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cpu_req) begin
                        if (any_hit) begin
                            way_q   <= hit_way;
                            cpu_ack <= 1'b1;
                            state   <= RESPOND;
                        end else begin
                            way_q      <= ctrl.lru;
                            wb_pending <= ctrl.dirty;
                            mem_cyc    <= 1'b1;
                            mem_stb    <= 1'b1;
                            mem_we     <= 1'b0;
                            mem_sel    <= '1;
                            state      <= FILL;
                        end
                    end
                end
                FILL: begin
                    if (mem_ack) begin
                        mem_cyc <= 1'b0;
                        mem_stb <= 1'b0;
                        mem_sel <= '0;
                        cpu_ack <= 1'b1;
                        state   <= RESPOND;
                    end
                end
                RESPOND: begin
                    cpu_ack <= 1'b0;
                    // Victim goes out only after the CPU has its ack
                    if (wb_pending) begin
                        mem_cyc <= 1'b1;
                        mem_stb <= 1'b1;
                        mem_we  <= 1'b1;
                        mem_sel <= '1;
                        state   <= WRITEBACK;
                    end else begin
                        state <= IDLE;
                    end
                end
                WRITEBACK: begin
                    if (mem_ack) begin
                        mem_cyc    <= 1'b0;
                        mem_stb    <= 1'b0;
                        mem_we     <= 1'b0;
                        mem_sel    <= '0;
                        wb_pending <= 1'b0;
                        state      <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== rtl/eviction_buffered_cache.sv ====
`timescale 1ns/10ps

module eviction_buffered_cache
    import cache_pkg::*;
#(
    parameter int NUM_LINES     = 8,
    parameter int ASSOCIATIVITY = 2
) (
    input  logic              clk,
    input  logic              rst,

    // CPU side, Wishbone slave
    input  logic              cpu_cyc,
    input  logic              cpu_stb,
    input  logic              cpu_we,
    input  logic [ADDR_W-1:0] cpu_adr,
    input  logic [SEL_W-1:0]  cpu_sel,
    input  logic [LINE_W-1:0] cpu_dat_m,
    output logic [LINE_W-1:0] cpu_dat_s,
    output logic              cpu_ack,

    // Memory side, Wishbone master
    output logic              mem_cyc,
    output logic              mem_stb,
    output logic              mem_we,
    output logic [ADDR_W-1:0] mem_adr,
    output logic [SEL_W-1:0]  mem_sel,
    output logic [LINE_W-1:0] mem_dat_m,
    input  logic [LINE_W-1:0] mem_dat_s,
    input  logic              mem_ack
);
    cache_ctrl_if #(.ASSOCIATIVITY(ASSOCIATIVITY)) ctrl_if ();

    // Controller to eviction buffer
    logic              victim_load;
    mem_src_e          mem_src;

    // Datapath to eviction buffer
    logic [ADDR_W-1:0] fill_addr;
    logic [ADDR_W-1:0] victim_addr;
    logic [LINE_W-1:0] victim_data;

    cache_datapath #(
        .NUM_LINES     (NUM_LINES),
        .ASSOCIATIVITY (ASSOCIATIVITY)
    ) u_datapath (
        .clk         (clk),
        .rst         (rst),
        .ctrl        (ctrl_if.datapath),
        .cpu_adr     (cpu_adr),
        .cpu_sel     (cpu_sel),
        .cpu_dat_m   (cpu_dat_m),
        .mem_dat_s   (mem_dat_s),
        .cpu_dat_s   (cpu_dat_s),
        .fill_addr   (fill_addr),
        .victim_addr (victim_addr),
        .victim_data (victim_data)
    );

    eviction_buffer u_eviction_buffer (
        .clk         (clk),
        .rst         (rst),
        .victim_load (victim_load),
        .mem_src     (mem_src),
        .fill_addr   (fill_addr),
        .victim_addr (victim_addr),
        .victim_data (victim_data),
        .mem_adr     (mem_adr),
        .mem_dat_m   (mem_dat_m)
    );

    eviction_buffered_cache_controller #(
        .ASSOCIATIVITY (ASSOCIATIVITY)
    ) u_controller (
        .clk         (clk),
        .rst         (rst),
        .ctrl        (ctrl_if.controller),
        .cpu_cyc     (cpu_cyc),
        .cpu_stb     (cpu_stb),
        .cpu_we      (cpu_we),
        .mem_ack     (mem_ack),
        .cpu_ack     (cpu_ack),
        .mem_cyc     (mem_cyc),
        .mem_stb     (mem_stb),
        .mem_we      (mem_we),
        .mem_sel     (mem_sel),
        .victim_load (victim_load),
        .mem_src     (mem_src)
    );

endmodule

// ==== test/tb_eviction_buffered_cache.sv ====
`timescale 1ns/10ps

module tb_eviction_buffered_cache
    import cache_pkg::*;
();
    localparam int NUM_LINES     = 8;
    localparam int ASSOCIATIVITY = 2;
    localparam int SETS          = NUM_LINES / ASSOCIATIVITY;
    localparam int TIMEOUT       = 200;
    localparam int NUM_ACCESSES  = 400;

    logic              clk;
    logic              rst;
    logic              cpu_cyc, cpu_stb, cpu_we, cpu_ack;
    logic [ADDR_W-1:0] cpu_adr;
    logic [SEL_W-1:0]  cpu_sel;
    logic [LINE_W-1:0] cpu_dat_m, cpu_dat_s;
    logic              mem_cyc, mem_stb, mem_we, mem_ack;
    logic [ADDR_W-1:0] mem_adr;
    logic [SEL_W-1:0]  mem_sel;
    logic [LINE_W-1:0] mem_dat_m, mem_dat_s;

    // Reference model of the cache and of the memory behind it
    logic [LINE_W-1:0] m_data  [SETS][ASSOCIATIVITY];
    int                m_tag   [SETS][ASSOCIATIVITY];
    int                m_age   [SETS][ASSOCIATIVITY];
    bit                m_valid [SETS][ASSOCIATIVITY];
    bit                m_dirty [SETS][ASSOCIATIVITY];
    logic [LINE_W-1:0] ref_mem [int];

    // Memory served to the DUT and the log of its transfers
    logic [LINE_W-1:0] mem_store [int];
    logic              ev_we  [$];
    logic [ADDR_W-1:0] ev_adr [$];
    logic [LINE_W-1:0] ev_dat [$];

    // Sets 0 and 1 get more tags than ways
    logic [ADDR_W-1:0] addr_pool [8] = '{16'h0000, 16'h0040, 16'h0080, 16'h00c0,
                                         16'h1010, 16'h1050, 16'h2090, 16'h3020};

    bit                wb_expected;
    logic [ADDR_W-1:0] wb_adr;
    logic [LINE_W-1:0] wb_dat;
    int                dirty_evictions;
    int                clean_evictions;

    eviction_buffered_cache #(
        .NUM_LINES     (NUM_LINES),
        .ASSOCIATIVITY (ASSOCIATIVITY)
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Distinct initial memory contents for every line address
    function automatic logic [LINE_W-1:0] fill_pattern(input logic [ADDR_W-1:0] a);
        logic [LINE_W-1:0] p;
        for (int k = 0; k < LINE_W / 16; k++) begin
            p[16*k +: 16] = a ^ 16'(k * 16'h1357);
        end
        return p;
    endfunction

    task automatic check_value(input string name, input logic [LINE_W-1:0] actual,
                               input logic [LINE_W-1:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic fail_with(input string reason);
        $display("Error at %0t ns: %s", $time, reason);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // One memory transfer acked after 1 to 4 cycles
    task automatic serve_memory();
        int                delay;
        logic [ADDR_W-1:0] a;
        delay = $urandom_range(1, 4);
        a = mem_adr;
        check_value("mem_sel", LINE_W'(mem_sel), LINE_W'({SEL_W{1'b1}}));
        for (int i = 0; i < delay; i++) begin
            @(negedge clk);
            if (!(mem_cyc && mem_stb)) begin
                fail_with("memory request dropped before its ack");
            end
            check_value("mem_adr", LINE_W'(mem_adr), LINE_W'(a));
        end
        ev_we.push_back(mem_we);
        ev_adr.push_back(a);
        if (mem_we) begin
            ev_dat.push_back(mem_dat_m);
            mem_store[int'(a)] = mem_dat_m;
        end else begin
            mem_dat_s = mem_store.exists(int'(a)) ? mem_store[int'(a)] : fill_pattern(a);
        end
        mem_ack = 1'b1;
        @(negedge clk);
        mem_ack = 1'b0;
    endtask

    initial begin
        mem_ack   = 1'b0;
        mem_dat_s = '0;
        forever begin
            @(negedge clk);
            if (!rst && mem_cyc && mem_stb) begin
                serve_memory();
            end
        end
    end

    // Model update for one access with LRU by ages
    task automatic model_access(input logic we, input logic [ADDR_W-1:0] adr,
                                input logic [SEL_W-1:0] sel, input logic [LINE_W-1:0] dat,
                                output bit hit, output logic [LINE_W-1:0] rd_line);
        int line;
        int idx;
        int tg;
        int way;
        int vadr;
        line = int'(adr) / 16;
        idx  = line % SETS;
        tg   = line / SETS;
        way  = -1;
        for (int w = 0; w < ASSOCIATIVITY; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tg) begin
                way = w;
            end
        end
        hit = (way >= 0);
        if (!hit) begin
            way = 0;
            for (int w = 1; w < ASSOCIATIVITY; w++) begin
                if (m_age[idx][w] > m_age[idx][way]) begin
                    way = w;
                end
            end
            for (int w = ASSOCIATIVITY - 1; w >= 0; w--) begin
                if (!m_valid[idx][w]) begin
                    way = w;
                end
            end
            if (m_valid[idx][way] && m_dirty[idx][way]) begin
                vadr = (m_tag[idx][way] * SETS + idx) * 16;
                ref_mem[vadr] = m_data[idx][way];
                wb_expected   = 1'b1;
                wb_adr        = ADDR_W'(vadr);
                wb_dat        = m_data[idx][way];
                dirty_evictions++;
            end else if (m_valid[idx][way]) begin
                clean_evictions++;
            end
            m_data[idx][way]  = ref_mem.exists(line * 16) ? ref_mem[line * 16]
                                                          : fill_pattern(ADDR_W'(line * 16));
            m_tag[idx][way]   = tg;
            m_valid[idx][way] = 1'b1;
            m_dirty[idx][way] = 1'b0;
        end
        rd_line = m_data[idx][way];
        if (we) begin
            for (int b = 0; b < SEL_W; b++) begin
                if (sel[b]) begin
                    m_data[idx][way][8*b +: 8] = dat[8*b +: 8];
                end
            end
            m_dirty[idx][way] = 1'b1;
        end
        for (int w = 0; w < ASSOCIATIVITY; w++) begin
            if (w != way && m_age[idx][w] < m_age[idx][way]) begin
                m_age[idx][w]++;
            end
        end
        m_age[idx][way] = 0;
    endtask

    task automatic expect_transfer(input logic we, input logic [ADDR_W-1:0] adr,
                                   input logic [LINE_W-1:0] dat);
        if (ev_we.size() == 0) begin
            if (we) begin
                fail_with("victim write-back did not complete before the next cpu_ack");
            end else begin
                fail_with("a miss was acked without a memory read");
            end
        end
        check_value("mem_we", LINE_W'(ev_we.pop_front()), LINE_W'(we));
        check_value("mem_adr", LINE_W'(ev_adr.pop_front()), LINE_W'(adr));
        if (we) begin
            check_value("mem_dat_m", ev_dat.pop_front(), dat);
        end
    endtask

    // Drive one CPU request and check everything up to its ack
    task automatic do_access(input logic we, input logic [ADDR_W-1:0] adr,
                             input logic [SEL_W-1:0] sel, input logic [LINE_W-1:0] dat);
        bit                hit;
        bit                prev_wb;
        logic [ADDR_W-1:0] prev_adr;
        logic [LINE_W-1:0] prev_dat;
        logic [LINE_W-1:0] rd_line;
        int                cycles;
        prev_wb     = wb_expected;
        prev_adr    = wb_adr;
        prev_dat    = wb_dat;
        wb_expected = 1'b0;
        model_access(we, adr, sel, dat, hit, rd_line);
        cpu_cyc   = 1'b1;
        cpu_stb   = 1'b1;
        cpu_we    = we;
        cpu_adr   = adr;
        cpu_sel   = sel;
        cpu_dat_m = dat;
        cycles    = 0;
        while (cpu_ack !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_with("no cpu_ack within the timeout");
            end
        end
        // Previous victim first and then this access's fill
        if (prev_wb) begin
            expect_transfer(1'b1, prev_adr, prev_dat);
        end
        if (!hit) begin
            expect_transfer(1'b0, {adr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}}, rd_line);
        end
        check_value("extra memory transfers", LINE_W'(ev_we.size()), '0);
        if (hit && !prev_wb) begin
            check_value("cpu_ack latency", LINE_W'(cycles), LINE_W'(1));
        end
        if (!we) begin
            check_value("cpu_dat_s", cpu_dat_s, rd_line);
        end
        @(negedge clk);
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
    endtask

    initial begin
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [SEL_W-1:0]  sel;
        logic [LINE_W-1:0] dat;
        int                cycles;
        void'($urandom(11));
        rst       = 1'b1;
        cpu_cyc   = 1'b0;
        cpu_stb   = 1'b0;
        cpu_we    = 1'b0;
        cpu_adr   = '0;
        cpu_sel   = '0;
        cpu_dat_m = '0;
        wb_expected     = 1'b0;
        dirty_evictions = 0;
        clean_evictions = 0;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < ASSOCIATIVITY; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_age[s][w]   = w;
            end
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("cpu_ack", LINE_W'(cpu_ack), '0);
        check_value("mem_cyc", LINE_W'(mem_cyc), '0);
        check_value("mem_stb", LINE_W'(mem_stb), '0);

        for (int i = 0; i < NUM_ACCESSES; i++) begin
            we  = $urandom_range(0, 1);
            adr = addr_pool[$urandom_range(0, 7)] | ADDR_W'($urandom_range(0, 15));
            sel = SEL_W'($urandom);
            dat = {$urandom, $urandom, $urandom, $urandom};
            do_access(we, adr, sel, dat);
        end

        // Last dirty victim may still be on its way out
        if (wb_expected) begin
            cycles = 0;
            while (ev_we.size() == 0) begin
                @(negedge clk);
                cycles++;
                if (cycles > TIMEOUT) begin
                    fail_with("final victim write-back never completed");
                end
            end
            expect_transfer(1'b1, wb_adr, wb_dat);
        end

        if (dirty_evictions > 0 && clean_evictions > 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            fail_with("random run missed a dirty or a clean eviction");
        end
    end

endmodule

// ==== eviction_buffered_cache.f ====
rtl/cache_pkg.sv
rtl/cache_ctrl_if.sv
rtl/cache_datapath.sv
rtl/eviction_buffer.sv
rtl/eviction_buffered_cache_controller.sv
rtl/eviction_buffered_cache.sv
test/tb_eviction_buffered_cache.sv

// ==== Bender.yml ====
package:
  name: eviction_buffered_cache

sources:
  - rtl/cache_pkg.sv
  - rtl/cache_ctrl_if.sv
  - rtl/cache_datapath.sv
  - rtl/eviction_buffer.sv
  - rtl/eviction_buffered_cache_controller.sv
  - rtl/eviction_buffered_cache.sv
  - target: test
    files:
      - test/tb_eviction_buffered_cache.sv
